//--- common/exu_consts.svh
// ==========================================================
// widths and step counts of the integer execute unit
// EXU_MUL_STEPS must stay equal to EXU_XLEN
// ==========================================================

`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// data path width
`define EXU_XLEN 64

// word operations use the low half
`define EXU_WORD_W 32

`define EXU_SHAMT_W 6

// one shift-add step per multiplier bit
`define EXU_MUL_STEPS `EXU_XLEN

`endif

//--- common/exu_pkg.sv
// ==========================================================
// operation codes and multiply sign modes
// mul_sign_t encodes operand signedness as {a, b}
// ==========================================================

`default_nettype none

package exu_pkg;

    // ==========================================================
    // operations accepted at issue
    // ==========================================================
    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_slt    = 4'd2,
        op_sltu   = 4'd3,
        op_and    = 4'd4,
        op_or     = 4'd5,
        op_xor    = 4'd6,
        op_sll    = 4'd7,
        op_srl    = 4'd8,
        op_sra    = 4'd9,
        op_pass_b = 4'd10,
        op_mul    = 4'd11,
        op_mulh   = 4'd12,
        op_mulhsu = 4'd13,
        op_mulhu  = 4'd14
    } alu_op_t;

    // bit 1 marks multiplicand signed, bit 0 multiplier signed
    typedef enum logic [1:0] {
        mul_uu = 2'b00,
        mul_su = 2'b10,
        mul_ss = 2'b11
    } mul_sign_t;

endpackage

`default_nettype wire

//--- alu/exu_shifter.sv
// ==========================================================
// barrel shifter, left or right, logical or arithmetic
// word mode shifts by 5 bits and sign-extends bit 31
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module exu_shifter (
    input  logic [`EXU_XLEN-1:0]    din,
    input  logic [`EXU_SHAMT_W-1:0] shamt,
    input  logic                    word,
    input  logic                    left,
    input  logic                    arith,
    output logic [`EXU_XLEN-1:0]    dout
);

    localparam int WORD_SHAMT_W = $clog2(`EXU_WORD_W);

    logic [`EXU_SHAMT_W-1:0] amt;
    logic                    fill;
    logic [`EXU_XLEN-1:0]    src;
    logic [2*`EXU_XLEN-1:0]  right_ext;
    logic [`EXU_XLEN-1:0]    raw;

    assign amt  = word ? {{(`EXU_SHAMT_W-WORD_SHAMT_W){1'b0}}, shamt[WORD_SHAMT_W-1:0]} : shamt;
    assign fill = arith & (word ? din[`EXU_WORD_W-1] : din[`EXU_XLEN-1]);

    // word operand gets its sign or zero fill above bit 31
    assign src = word ? {{(`EXU_XLEN-`EXU_WORD_W){fill}}, din[`EXU_WORD_W-1:0]} : din;

    assign right_ext = {{`EXU_XLEN{fill}}, src} >> amt;
    assign raw       = left ? (src << amt) : right_ext[`EXU_XLEN-1:0];

    assign dout = word ? {{(`EXU_XLEN-`EXU_WORD_W){raw[`EXU_WORD_W-1]}}, raw[`EXU_WORD_W-1:0]} :
                  raw;

endmodule

`default_nettype wire

//--- alu/exu_int_alu.sv
// ==========================================================
// single-cycle ALU, purely combinational
// word flag only affects add, sub and the shifts
// less and zero are low except for sub, slt and sltu
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module exu_int_alu (
    input  exu_pkg::alu_op_t     op,
    input  logic                 word,
    input  logic [`EXU_XLEN-1:0] da,
    input  logic [`EXU_XLEN-1:0] db,
    output logic [`EXU_XLEN-1:0] alu_result,
    output logic                 alu_less,
    output logic                 alu_zero
);

    import exu_pkg::*;

    logic                 is_add;
    logic                 is_sub;
    logic                 is_slt;
    logic                 is_sltu;
    logic                 sub_sel;
    logic [`EXU_XLEN-1:0] db_op;
    logic [`EXU_XLEN-1:0] sum;
    logic                 carry;
    logic                 ovf;
    logic                 less_s;
    logic                 less_u;
    logic [`EXU_XLEN-1:0] shift_out;
    logic [`EXU_XLEN-1:0] sel_out;

    assign is_add  = (op == op_add);
    assign is_sub  = (op == op_sub);
    assign is_slt  = (op == op_slt);
    assign is_sltu = (op == op_sltu);
    assign sub_sel = is_sub | is_slt | is_sltu;

    // ==========================================================
    // shared adder, subtract by invert and carry in
    // ==========================================================
    assign db_op = db ^ {`EXU_XLEN{sub_sel}};
    assign {carry, sum} = {1'b0, da} + {1'b0, db_op} + {{`EXU_XLEN{1'b0}}, sub_sel};

    assign ovf    = (da[`EXU_XLEN-1] == db_op[`EXU_XLEN-1]) &&
                    (sum[`EXU_XLEN-1] != da[`EXU_XLEN-1]);
    assign less_s = ovf ^ sum[`EXU_XLEN-1];
    // no carry out means a borrow
    assign less_u = ~carry;

    assign alu_less = ((is_sub | is_slt) & less_s) | (is_sltu & less_u);
    assign alu_zero = sub_sel & (sum == '0);

    exu_shifter i_exu_shifter (
        .din   (da),
        .shamt (db[`EXU_SHAMT_W-1:0]),
        .word  (word),
        .left  (op == op_sll),
        .arith (op == op_sra),
        .dout  (shift_out)
    );

    // one-hot select, multiply ops fall through to zero
    assign sel_out = ({`EXU_XLEN{is_add | is_sub}} & sum) |
                     ({`EXU_XLEN{is_slt}} & {{(`EXU_XLEN-1){1'b0}}, less_s}) |
                     ({`EXU_XLEN{is_sltu}} & {{(`EXU_XLEN-1){1'b0}}, less_u}) |
                     ({`EXU_XLEN{op == op_and}} & (da & db)) |
                     ({`EXU_XLEN{op == op_or}} & (da | db)) |
                     ({`EXU_XLEN{op == op_xor}} & (da ^ db)) |
                     ({`EXU_XLEN{op inside {op_sll, op_srl, op_sra}}} & shift_out) |
                     ({`EXU_XLEN{op == op_pass_b}} & db);

    // shifter already extends its own word result
    assign alu_result = (word && (is_add || is_sub)) ?
                        {{(`EXU_XLEN-`EXU_WORD_W){sel_out[`EXU_WORD_W-1]}},
                         sel_out[`EXU_WORD_W-1:0]} :
                        sel_out;

endmodule

`default_nettype wire

//--- muldiv/exu_mul_seq.sv
// ==========================================================
// iterative shift-add multiplier, one bit per cycle
// operands are sampled only at the valid/ready handshake
// product outputs hold until the next accepted request
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module exu_mul_seq (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mul_valid,
    output logic                 mul_ready,
    input  exu_pkg::mul_sign_t   mul_sign,
    input  logic [`EXU_XLEN-1:0] multiplicand,
    input  logic [`EXU_XLEN-1:0] multiplier,
    output logic                 mul_done,
    output logic [`EXU_XLEN-1:0] product_hi,
    output logic [`EXU_XLEN-1:0] product_lo
);

    import exu_pkg::*;

    localparam int CNT_W = $clog2(`EXU_MUL_STEPS);

    logic                   busy;
    logic [CNT_W-1:0]       step_cnt;
    logic                   last_step;
    logic [2*`EXU_XLEN-1:0] acc;
    logic [`EXU_XLEN-1:0]   mcand;
    logic                   neg;
    logic                   a_neg;
    logic                   b_neg;
    logic [`EXU_XLEN-1:0]   a_mag;
    logic [`EXU_XLEN-1:0]   b_mag;
    logic [`EXU_XLEN:0]     part;
    logic [2*`EXU_XLEN-1:0] prod;

    assign mul_ready = ~busy;
    assign last_step = (step_cnt == CNT_W'(`EXU_MUL_STEPS - 1));

    // magnitudes of the operands counted as signed
    assign a_neg = (mul_sign != mul_uu) & multiplicand[`EXU_XLEN-1];
    assign b_neg = (mul_sign == mul_ss) & multiplier[`EXU_XLEN-1];
    assign a_mag = a_neg ? -multiplicand : multiplicand;
    assign b_mag = b_neg ? -multiplier : multiplier;

    // upper half plus multiplicand when the low bit is set
    assign part = {1'b0, acc[2*`EXU_XLEN-1:`EXU_XLEN]} +
                  (acc[0] ? {1'b0, mcand} : {(`EXU_XLEN+1){1'b0}});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            step_cnt <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= busy & last_step;
            if (mul_valid && mul_ready) begin
                busy     <= 1'b1;
                step_cnt <= '0;
            end else if (busy) begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_valid && mul_ready) begin
            acc   <= {{`EXU_XLEN{1'b0}}, b_mag};
            mcand <= a_mag;
            neg   <= a_neg ^ b_neg;
        end else if (busy) begin
            acc <= {part, acc[`EXU_XLEN-1:1]};
        end
    end

    assign prod       = neg ? -acc : acc;
    assign product_hi = prod[2*`EXU_XLEN-1:`EXU_XLEN];
    assign product_lo = prod[`EXU_XLEN-1:0];

endmodule

`default_nettype wire

//--- logic/exu_op_ctrl.sv
// ==========================================================
// issue control, one operation in flight at a time
// single-cycle results stream, multiplies block issue
// results carry no back-pressure
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module exu_op_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  exu_pkg::alu_op_t     op,
    input  logic                 word,
    input  logic [`EXU_XLEN-1:0] da,
    input  logic [`EXU_XLEN-1:0] db,
    input  logic [`EXU_XLEN-1:0] alu_result,
    input  logic                 alu_less,
    input  logic                 alu_zero,
    output logic                 mul_valid,
    input  logic                 mul_ready,
    output exu_pkg::mul_sign_t   mul_sign,
    output logic [`EXU_XLEN-1:0] multiplicand,
    output logic [`EXU_XLEN-1:0] multiplier,
    input  logic                 mul_done,
    input  logic [`EXU_XLEN-1:0] product_hi,
    input  logic [`EXU_XLEN-1:0] product_lo,
    output logic                 result_valid,
    output logic [`EXU_XLEN-1:0] result,
    output logic                 less,
    output logic                 zero
);

    import exu_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_request,
        st_wait
    } ctrl_state_t;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        accept;
    logic        is_mul_op;
    logic        mul_word;
    logic        hi_q;
    logic        word_q;
    logic        mul_fin;

    assign issue_ready = (state == st_idle);
    assign mul_valid   = (state == st_request);
    assign accept      = issue_valid & issue_ready;
    assign is_mul_op   = op inside {op_mul, op_mulh, op_mulhsu, op_mulhu};
    // only mul-low honours the word flag
    assign mul_word    = word & (op == op_mul);
    assign mul_fin     = (state == st_wait) & mul_done;

    // ==========================================================
    // state machine
    // ==========================================================
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (accept && is_mul_op) begin
                    state_nxt = st_request;
                end
            end
            st_request: begin
                if (mul_ready) begin
                    state_nxt = st_wait;
                end
            end
            st_wait: begin
                if (mul_done) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_idle;
            result_valid <= 1'b0;
        end else begin
            state        <= state_nxt;
            result_valid <= (accept & ~is_mul_op) | mul_fin;
        end
    end

    // multiply request fields, held through REQUEST
    always_ff @(posedge clk) begin
        if (accept && is_mul_op) begin
            multiplicand <= mul_word ? {{(`EXU_XLEN-`EXU_WORD_W){1'b0}}, da[`EXU_WORD_W-1:0]} : da;
            multiplier   <= mul_word ? {{(`EXU_XLEN-`EXU_WORD_W){1'b0}}, db[`EXU_WORD_W-1:0]} : db;
            mul_sign     <= (op == op_mulh) ? mul_ss : ((op == op_mulhsu) ? mul_su : mul_uu);
            hi_q         <= (op != op_mul);
            word_q       <= mul_word;
        end
    end

    // ==========================================================
    // result register
    // ==========================================================
    always_ff @(posedge clk) begin
        if (accept && !is_mul_op) begin
            result <= alu_result;
            less   <= alu_less;
            zero   <= alu_zero;
        end else if (mul_fin) begin
            result <= hi_q ? product_hi :
                      (word_q ? {{(`EXU_XLEN-`EXU_WORD_W){product_lo[`EXU_WORD_W-1]}},
                                 product_lo[`EXU_WORD_W-1:0]} : product_lo);
            less   <= 1'b0;
            zero   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/exu_alu_top.sv
// ==========================================================
// integer execute unit top level
// issue is valid/ready, results have no back-pressure
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module exu_alu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  exu_pkg::alu_op_t     op,
    input  logic                 word,
    input  logic [`EXU_XLEN-1:0] da,
    input  logic [`EXU_XLEN-1:0] db,
    output logic                 result_valid,
    output logic [`EXU_XLEN-1:0] result,
    output logic                 less,
    output logic                 zero
);

    import exu_pkg::*;

    logic [`EXU_XLEN-1:0] alu_result;
    logic                 alu_less;
    logic                 alu_zero;
    logic                 mul_valid;
    logic                 mul_ready;
    mul_sign_t            mul_sign;
    logic [`EXU_XLEN-1:0] multiplicand;
    logic [`EXU_XLEN-1:0] multiplier;
    logic                 mul_done;
    logic [`EXU_XLEN-1:0] product_hi;
    logic [`EXU_XLEN-1:0] product_lo;

    exu_op_ctrl i_exu_op_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .op           (op),
        .word         (word),
        .da           (da),
        .db           (db),
        .alu_result   (alu_result),
        .alu_less     (alu_less),
        .alu_zero     (alu_zero),
        .mul_valid    (mul_valid),
        .mul_ready    (mul_ready),
        .mul_sign     (mul_sign),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .mul_done     (mul_done),
        .product_hi   (product_hi),
        .product_lo   (product_lo),
        .result_valid (result_valid),
        .result       (result),
        .less         (less),
        .zero         (zero)
    );

    exu_int_alu i_exu_int_alu (
        .op         (op),
        .word       (word),
        .da         (da),
        .db         (db),
        .alu_result (alu_result),
        .alu_less   (alu_less),
        .alu_zero   (alu_zero)
    );

    exu_mul_seq i_exu_mul_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .mul_valid    (mul_valid),
        .mul_ready    (mul_ready),
        .mul_sign     (mul_sign),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .mul_done     (mul_done),
        .product_hi   (product_hi),
        .product_lo   (product_lo)
    );

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
// ==========================================================
// testbench clock and reset, reset released on a falling edge
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- test/tb_exu_alu_props.sv
// ==========================================================
// handshake properties of the issue controller
// disabled while reset is asserted
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

module tb_exu_alu_props (
    input logic clk,
    input logic rst_n,
    input logic mul_valid,
    input logic mul_ready,
    input logic issue_ready,
    input logic result_valid
);

    int fail_cnt = 0;

    // request held until the multiplier takes it, then dropped
    mul_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mul_valid |=> (mul_valid != $past(mul_ready)))
        else begin
            $error("mul_valid not held until mul_ready or not dropped after it");
            fail_cnt++;
        end

    // issue reopens only together with the multiply result
    issue_closed_in_mul: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(issue_ready) |-> result_valid)
        else begin
            $error("issue_ready reopened without a multiply result");
            fail_cnt++;
        end

    no_result_in_mul: assert property (@(posedge clk) disable iff (!rst_n)
        !(result_valid && mul_valid))
        else begin
            $error("result_valid together with mul_valid");
            fail_cnt++;
        end

endmodule

bind exu_op_ctrl tb_exu_alu_props i_op_ctrl_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .mul_valid    (mul_valid),
    .mul_ready    (mul_ready),
    .issue_ready  (issue_ready),
    .result_valid (result_valid)
);

`default_nettype wire

//--- test/tb_exu_alu.sv
// ==========================================================
// random testbench for the execute unit, fixed LFSR seed
// expected results queued at acceptance, checked in order
// outputs sampled and inputs driven on the falling edge
// ==========================================================

`timescale 1ns/10ps
`default_nettype none

`include "exu_consts.svh"

module tb_exu_alu;

    import exu_pkg::*;

    localparam int N_SINGLE  = 200;
    localparam int N_CMP_RND = 16;
    localparam int N_FORCED  = 9;
    localparam int N_OTHER   = 20;
    localparam int N_MUL     = 60;
    localparam int N_MIX     = 80;
    localparam int N_TOTAL   = N_SINGLE + 3 * (N_CMP_RND + N_FORCED) + N_OTHER + N_MUL + N_MIX;
    localparam int WATCHDOG_CYCLES = (N_TOTAL + 16) * (`EXU_MUL_STEPS + 8);

    typedef struct packed {
        logic [`EXU_XLEN-1:0] result;
        logic                 less;
        logic                 zero;
        logic                 is_mul;
    } exp_t;

    logic                 clk;
    logic                 rst_n;
    logic                 issue_valid;
    logic                 issue_ready;
    alu_op_t              op;
    logic                 word;
    logic [`EXU_XLEN-1:0] da;
    logic [`EXU_XLEN-1:0] db;
    logic                 result_valid;
    logic [`EXU_XLEN-1:0] result;
    logic                 less;
    logic                 zero;

    exp_t        exp_q[$];
    logic [31:0] lfsr_state;
    int          checks;
    int          errors;
    int          test_errors;
    int          mul_outstanding;

    tb_clk_gen i_tb_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    exu_alu_top i_exu_alu_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .op           (op),
        .word         (word),
        .da           (da),
        .db           (db),
        .result_valid (result_valid),
        .result       (result),
        .less         (less),
        .zero         (zero)
    );

    // ==========================================================
    // random source and reference model
    // ==========================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // zero, all ones and most negative show up often
    function automatic logic [63:0] rand_operand();
        logic [2:0] sel;
        sel = 3'(take_bits(3));
        case (sel)
            3'd0:    return 64'h0;
            3'd1:    return '1;
            3'd2:    return 64'h8000_0000_0000_0000;
            default: return take_bits(64);
        endcase
    endfunction

    function automatic alu_op_t rand_plain_op();
        alu_op_t ops[8];
        ops = '{op_add, op_and, op_or, op_xor, op_sll, op_srl, op_sra, op_pass_b};
        return ops[3'(take_bits(3))];
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic exp_t model_op(input alu_op_t o, input logic w,
                                      input logic [63:0] a, input logic [63:0] b);
        exp_t         e;
        logic [127:0] p;
        logic [31:0]  lo32;
        e = '0;
        case (o)
            op_add:    e.result = w ? sext32(a[31:0] + b[31:0]) : a + b;
            op_sub:    e.result = w ? sext32(a[31:0] - b[31:0]) : a - b;
            op_slt:    e.result = {63'b0, $signed(a) < $signed(b)};
            op_sltu:   e.result = {63'b0, a < b};
            op_and:    e.result = a & b;
            op_or:     e.result = a | b;
            op_xor:    e.result = a ^ b;
            op_sll:    e.result = w ? sext32(a[31:0] << b[4:0]) : a << b[5:0];
            op_srl:    e.result = w ? sext32(a[31:0] >> b[4:0]) : a >> b[5:0];
            op_sra: begin
                lo32 = $signed(a[31:0]) >>> b[4:0];
                if (w) begin
                    e.result = sext32(lo32);
                end else begin
                    e.result = $signed(a) >>> b[5:0];
                end
            end
            op_pass_b: e.result = b;
            op_mul: begin
                if (w) begin
                    p = {96'b0, a[31:0]} * {96'b0, b[31:0]};
                    e.result = sext32(p[31:0]);
                end else begin
                    p = {64'b0, a} * {64'b0, b};
                    e.result = p[63:0];
                end
            end
            op_mulh: begin
                p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
                e.result = p[127:64];
            end
            op_mulhsu: begin
                p = {{64{a[63]}}, a} * {64'b0, b};
                e.result = p[127:64];
            end
            op_mulhu: begin
                p = {64'b0, a} * {64'b0, b};
                e.result = p[127:64];
            end
            default: e.result = '0;
        endcase
        if (o inside {op_sub, op_slt, op_sltu}) begin
            e.less = (o == op_sltu) ? (a < b) : ($signed(a) < $signed(b));
            e.zero = (a == b);
        end
        e.is_mul = o inside {op_mul, op_mulh, op_mulhsu, op_mulhu};
        return e;
    endfunction

    // ==========================================================
    // checks, issue and result monitor
    // ==========================================================
    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
        checks++;
        assert (got === want) else begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, want);
            errors++;
            test_errors++;
        end
    endtask

    // issue must stay closed while a multiply is in flight
    task automatic check_gate();
        if (issue_ready && !result_valid) begin
            checks++;
            assert (mul_outstanding == 0) else begin
                $display("issue_ready went high before the multiply result arrived");
                errors++;
                test_errors++;
            end
        end
    endtask

    task automatic issue_op(input alu_op_t o, input logic w,
                            input logic [63:0] a, input logic [63:0] b);
        exp_t e;
        @(negedge clk);
        issue_valid = 1'b1;
        op          = o;
        word        = w;
        da          = a;
        db          = b;
        check_gate();
        while (!issue_ready) begin
            @(negedge clk);
            check_gate();
        end
        e = model_op(o, w, a, b);
        exp_q.push_back(e);
        if (e.is_mul) begin
            mul_outstanding++;
        end
    endtask

    // equal, zero, all ones and signed boundary pairs
    task automatic forced_pair(input int idx, output logic [63:0] a, output logic [63:0] b);
        case (idx)
            0:       a = take_bits(64);
            1, 2:    a = 64'h0;
            4, 6:    a = 64'h8000_0000_0000_0000;
            5:       a = 64'h7fff_ffff_ffff_ffff;
            7:       a = 64'h1;
            default: a = '1;
        endcase
        case (idx)
            0:       b = a;
            1, 3, 7: b = 64'h0;
            2:       b = '1;
            4:       b = 64'h7fff_ffff_ffff_ffff;
            5, 6:    b = 64'h8000_0000_0000_0000;
            default: b = 64'h1;
        endcase
    endtask

    task automatic end_test(input string name);
        @(negedge clk);
        issue_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        if (test_errors == 0) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    always @(negedge clk) begin
        exp_t e;
        if (rst_n && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("result_valid raised with no operation outstanding");
                errors++;
                test_errors++;
            end else begin
                e = exp_q.pop_front();
                check_val("result", result, e.result);
                check_val("less", {63'b0, less}, {63'b0, e.less});
                check_val("zero", {63'b0, zero}, {63'b0, e.zero});
                if (e.is_mul) begin
                    mul_outstanding--;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before all tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    // ==========================================================
    // test sequence
    // ==========================================================
    initial begin
        alu_op_t     o;
        logic [63:0] a;
        logic [63:0] b;
        int          prop_fails;
        issue_valid     = 1'b0;
        op              = op_add;
        word            = 1'b0;
        da              = '0;
        db              = '0;
        lfsr_state      = 32'h62bf;
        checks          = 0;
        errors          = 0;
        test_errors     = 0;
        mul_outstanding = 0;

        @(posedge rst_n);
        @(negedge clk);
        check_val("issue_ready", {63'b0, issue_ready}, 64'h1);
        check_val("result_valid", {63'b0, result_valid}, 64'h0);
        end_test("reset");

        for (int i = 0; i < N_SINGLE; i++) begin
            o = alu_op_t'(4'(take_bits(4) % 11));
            a = take_bits(64);
            b = take_bits(64);
            issue_op(o, 1'(take_bits(1)), a, b);
        end
        end_test("single_cycle");

        for (int k = 0; k < 3; k++) begin
            o = (k == 0) ? op_sub : ((k == 1) ? op_slt : op_sltu);
            for (int i = 0; i < N_CMP_RND + N_FORCED; i++) begin
                if (i < N_CMP_RND) begin
                    a = take_bits(64);
                    b = take_bits(64);
                end else begin
                    forced_pair(i - N_CMP_RND, a, b);
                end
                issue_op(o, 1'(take_bits(1)), a, b);
            end
        end
        for (int i = 0; i < N_OTHER; i++) begin
            o = rand_plain_op();
            a = take_bits(64);
            b = take_bits(64);
            issue_op(o, 1'(take_bits(1)), a, b);
        end
        end_test("compare_flags");

        for (int i = 0; i < N_MUL; i++) begin
            o = alu_op_t'(4'(11 + take_bits(2)));
            a = rand_operand();
            b = rand_operand();
            issue_op(o, 1'(take_bits(1)), a, b);
        end
        end_test("multiply");

        for (int i = 0; i < N_MIX; i++) begin
            if (take_bits(2) == 0) begin
                o = alu_op_t'(4'(11 + take_bits(2)));
                a = rand_operand();
                b = rand_operand();
            end else begin
                o = alu_op_t'(4'(take_bits(4) % 11));
                a = take_bits(64);
                b = take_bits(64);
            end
            issue_op(o, 1'(take_bits(1)), a, b);
        end
        end_test("mixed");

        prop_fails = i_exu_alu_top.i_exu_op_ctrl.i_op_ctrl_props.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/exu_pkg.sv
alu/exu_shifter.sv
alu/exu_int_alu.sv
muldiv/exu_mul_seq.sv
logic/exu_op_ctrl.sv
logic/exu_alu_top.sv
test/tb_clk_gen.sv
test/tb_exu_alu_props.sv
test/tb_exu_alu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_exu_alu
RTL_TOP   ?= exu_alu_top
FILELIST  ?= project.f
RUNFLAGS  ?= +verilator+error+limit+1000
SIM       := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out=$$($(SIM) $(RUNFLAGS)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^TESTS PASSED$$'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
